// ==== logic/ex_pkg.sv ====
//////////////////////////////////////////////////
// Shared types for the execute stage
// Word, register address and hart ID widths
// ALU, compare and output select codes
// ID/EX request and EX/MEM result structs
//////////////////////////////////////////////////

`default_nettype none

package ex_pkg;

    //////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;                    // Data or address word
    typedef logic [4:0]  reg_addr_t;                // GPR address
    typedef logic [1:0]  hart_id_t;                 // Hardware thread ID

    //////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////

    typedef logic [3:0] alu_op_t;                   // ALU operation

    localparam alu_op_t ALU_ADD   = 4'd0;           // Add
    localparam alu_op_t ALU_SUB   = 4'd1;           // Subtract
    localparam alu_op_t ALU_AND   = 4'd2;           // Bitwise and
    localparam alu_op_t ALU_OR    = 4'd3;           // Bitwise or
    localparam alu_op_t ALU_XOR   = 4'd4;           // Bitwise xor
    localparam alu_op_t ALU_SLL   = 4'd5;           // Shift left logical
    localparam alu_op_t ALU_SRL   = 4'd6;           // Shift right logical
    localparam alu_op_t ALU_SRA   = 4'd7;           // Shift right arithmetic
    localparam alu_op_t ALU_SLT   = 4'd8;           // Set less than, signed
    localparam alu_op_t ALU_SLTU  = 4'd9;           // Set less than, unsigned
    localparam alu_op_t ALU_PASS1 = 4'd10;          // Pass operand 1 (LUI style)

    typedef logic [2:0] cmp_op_t;                   // Branch compare

    localparam cmp_op_t CMP_NONE = 3'd0;            // Not a branch
    localparam cmp_op_t CMP_EQ   = 3'd1;            // Equal
    localparam cmp_op_t CMP_NE   = 3'd2;            // Not equal
    localparam cmp_op_t CMP_LT   = 3'd3;            // Less than, signed
    localparam cmp_op_t CMP_GE   = 3'd4;            // Greater or equal, signed
    localparam cmp_op_t CMP_LTU  = 3'd5;            // Less than, unsigned
    localparam cmp_op_t CMP_GEU  = 3'd6;            // Greater or equal, unsigned

    typedef logic [1:0] out_sel_t;                  // Stage result select

    localparam out_sel_t OUT_ALU  = 2'd0;           // ALU result
    localparam out_sel_t OUT_LINK = 2'd1;           // Return address
    localparam out_sel_t OUT_GPR  = 2'd2;           // Side value from decode

    localparam word_t LINK_OFFSET = 32'd4;          // PC to link address

    //////////////////////////////////////////////////
    // Pipeline register payloads
    //////////////////////////////////////////////////

    // ID/EX request, first field in the top bits
    typedef struct packed {
        alu_op_t   alu_op;                          // ALU operation
        word_t     alu_in_0;                        // ALU operand 0
        word_t     alu_in_1;                        // ALU operand 1
        cmp_op_t   cmp_op;                          // Compare operation
        word_t     cmp_in_0;                        // Compare operand 0
        word_t     cmp_in_1;                        // Compare operand 1
        logic      jump_taken;                      // Unconditional jump
        logic      is_jalr;                         // JALR target fixup
        out_sel_t  out_sel;                         // Result select
        word_t     pc;                              // Program counter
        word_t     gpr_wr_data;                     // Side value for GPR
        reg_addr_t rd_addr;                         // Destination register
        logic      gpr_we;                          // GPR write enable
        hart_id_t  hart_id;                         // Issuing hart
    } ex_req_t;

    // EX/MEM result
    typedef struct packed {
        word_t     ex_out;                          // Stage output
        logic      br_taken;                        // Branch taken
        word_t     br_addr;                         // Branch target
        reg_addr_t rd_addr;                         // Destination register
        logic      gpr_we;                          // GPR write enable
        hart_id_t  hart_id;                         // Issuing hart
    } ex_rsp_t;

endpackage

`default_nettype wire

// ==== logic/alu_unit.sv ====
//////////////////////////////////////////////////
// Integer ALU of the execute stage
// Add, subtract, logic, shifts, set less than
// Purely combinational
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import ex_pkg::*;
(
    input  alu_op_t alu_op,                         // Operation select
    input  word_t   alu_in_0,                       // Operand 0
    input  word_t   alu_in_1,                       // Operand 1
    output word_t   alu_out                         // Result
);

    //////////////////////////////////////////////////
    // Shared operand views
    //////////////////////////////////////////////////

    logic [4:0] shamt;                              // Shift amount
    logic       lt_signed;                          // Signed compare
    logic       lt_unsigned;                        // Unsigned compare
    word_t      sum;                                // Adder output
    word_t      diff;                               // Subtractor output

    assign shamt       = alu_in_1[4:0];             // Low five bits only
    assign lt_signed   = $signed(alu_in_0) < $signed(alu_in_1);
    assign lt_unsigned = alu_in_0 < alu_in_1;       // Plain magnitude
    assign sum         = alu_in_0 + alu_in_1;       // Also branch target
    assign diff        = alu_in_0 - alu_in_1;       // Wraps on overflow

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        unique case (alu_op)
            ALU_ADD: begin
                alu_out = sum;                      // PC plus offset for jumps
            end
            ALU_SUB: begin
                alu_out = diff;
            end
            ALU_AND: begin
                alu_out = alu_in_0 & alu_in_1;
            end
            ALU_OR: begin
                alu_out = alu_in_0 | alu_in_1;
            end
            ALU_XOR: begin
                alu_out = alu_in_0 ^ alu_in_1;
            end
            ALU_SLL: begin
                alu_out = alu_in_0 << shamt;        // Zero fill
            end
            ALU_SRL: begin
                alu_out = alu_in_0 >> shamt;        // Zero fill
            end
            ALU_SRA: begin
                alu_out = word_t'($signed(alu_in_0) >>> shamt); // Sign fill
            end
            ALU_SLT: begin
                alu_out = {31'd0, lt_signed};       // One or zero
            end
            ALU_SLTU: begin
                alu_out = {31'd0, lt_unsigned};     // One or zero
            end
            ALU_PASS1: begin
                alu_out = alu_in_1;                 // Immediate through
            end
            default: begin
                alu_out = '0;                       // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/branch_cmp.sv ====
//////////////////////////////////////////////////
// Branch condition comparator
// Equality and signed or unsigned ordering
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_cmp
    import ex_pkg::*;
(
    input  cmp_op_t cmp_op,                         // Compare select
    input  word_t   cmp_in_0,                       // Operand 0
    input  word_t   cmp_in_1,                       // Operand 1
    output logic    cond_true                       // Condition holds
);

    logic is_eq;                                    // Operands equal
    logic is_lt;                                    // Signed less than
    logic is_ltu;                                   // Unsigned less than

    assign is_eq  = cmp_in_0 == cmp_in_1;
    assign is_lt  = $signed(cmp_in_0) < $signed(cmp_in_1);
    assign is_ltu = cmp_in_0 < cmp_in_1;

    // GE forms are the inverse of LT forms
    always_comb begin
        unique case (cmp_op)
            CMP_EQ: begin
                cond_true = is_eq;
            end
            CMP_NE: begin
                cond_true = !is_eq;
            end
            CMP_LT: begin
                cond_true = is_lt;
            end
            CMP_GE: begin
                cond_true = !is_lt;
            end
            CMP_LTU: begin
                cond_true = is_ltu;
            end
            CMP_GEU: begin
                cond_true = !is_ltu;
            end
            default: begin
                cond_true = 1'b0;                   // CMP_NONE never branches
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_result_reg.sv ====
//////////////////////////////////////////////////
// EX/MEM register with valid/ready handshake
// Output select and branch resolution
// One entry, one cycle latency
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_result_reg
    import ex_pkg::*;
(
    input  logic    clk,                            // Clock
    input  logic    rst_n,                          // Sync reset, active low
    input  logic    in_valid,                       // Request present
    output logic    in_ready,                       // Request taken
    input  ex_req_t req,                            // ID/EX request
    input  word_t   alu_out,                        // From ALU
    input  logic    cond_true,                      // From comparator
    output logic    out_valid,                      // Result present
    input  logic    out_ready,                      // Sink takes result
    output ex_rsp_t rsp                             // EX/MEM result
);

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    logic    accept;                                // Request transfers
    logic    taken;                                 // Branch resolved taken
    word_t   target;                                // Branch target
    word_t   stage_out;                             // Selected output
    ex_rsp_t rsp_next;                              // Next register value

    assign in_ready = !out_valid || out_ready;      // Slot empty or leaving
    assign accept   = in_valid && in_ready;

    //////////////////////////////////////////////////
    // Combining logic
    //////////////////////////////////////////////////

    assign taken = req.jump_taken || cond_true;     // Jump or condition

    // JALR clears bit 0 of the computed target
    always_comb begin
        target = alu_out;
        if (req.is_jalr) begin
            target[0] = 1'b0;                       // Halfword align
        end
        if (!taken) begin
            target = '0;                            // No target when not taken
        end
    end

    always_comb begin
        unique case (req.out_sel)
            OUT_LINK: begin
                stage_out = req.pc + LINK_OFFSET;   // Return address
            end
            OUT_GPR: begin
                stage_out = req.gpr_wr_data;        // Side value
            end
            default: begin
                stage_out = alu_out;                // OUT_ALU
            end
        endcase
    end

    always_comb begin
        rsp_next          = '0;
        rsp_next.ex_out   = stage_out;
        rsp_next.br_taken = taken;
        rsp_next.br_addr  = target;
        rsp_next.rd_addr  = req.rd_addr;            // Pass through
        rsp_next.gpr_we   = req.gpr_we;             // Pass through
        rsp_next.hart_id  = req.hart_id;            // Pass through
    end

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;                      // Empty after reset
            rsp       <= '0;
        end else begin
            if (accept) begin
                out_valid <= 1'b1;                  // New entry
                rsp       <= rsp_next;
            end else if (out_ready) begin
                out_valid <= 1'b0;                  // Entry left, nothing new
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
//////////////////////////////////////////////////
// Execute stage top level
// ALU and branch comparator in parallel
// Results combined in the EX/MEM register
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic    clk,                            // Clock
    input  logic    rst_n,                          // Sync reset, active low
    // ID/EX side
    input  logic    in_valid,                       // Request present
    output logic    in_ready,                       // Stage can take it
    input  ex_req_t req,                            // ID/EX request
    // EX/MEM side
    output logic    out_valid,                      // Result present
    input  logic    out_ready,                      // Sink takes result
    output ex_rsp_t rsp                             // EX/MEM result
);

    //////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////

    word_t alu_out;                                 // ALU result
    logic  cond_true;                               // Branch condition

    //////////////////////////////////////////////////
    // Parallel units
    //////////////////////////////////////////////////

    alu_unit u_alu (
        .alu_op    (req.alu_op),                    // Operation
        .alu_in_0  (req.alu_in_0),                  // Operand 0
        .alu_in_1  (req.alu_in_1),                  // Operand 1
        .alu_out   (alu_out)                        // Result
    );

    branch_cmp u_cmp (
        .cmp_op    (req.cmp_op),                    // Compare code
        .cmp_in_0  (req.cmp_in_0),                  // Operand 0
        .cmp_in_1  (req.cmp_in_1),                  // Operand 1
        .cond_true (cond_true)                      // Condition
    );

    //////////////////////////////////////////////////
    // Combine and register
    //////////////////////////////////////////////////

    ex_result_reg u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .req       (req),                           // Select and pass-through fields
        .alu_out   (alu_out),
        .cond_true (cond_true),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== bench/tb_ex_stage.sv ====
//////////////////////////////////////////////////
// Testbench for the execute stage
// Cases and expected results from a hex data file
// Random input gaps and output back-pressure
// Scoreboard queue, hold and handshake checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
    import ex_pkg::*;
();

    //////////////////////////////////////////////////
    // Constants and storage
    //////////////////////////////////////////////////

    localparam CASE_FILE = "bench/ex_cases.mem";
    localparam int          NUM_FIELDS   = 17;             // Words per case line
    localparam int          MAX_CASES    = 64;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRAIN_CYCLES = 5;              // Idle edges after last result
    localparam logic [31:0] END_MARK     = 32'hffff_ffff;  // Lone word after last case
    localparam logic [31:0] LFSR_SEED    = 32'd88062;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    ex_req_t     req;
    logic        out_valid;
    logic        out_ready;
    ex_rsp_t     rsp;

    logic [31:0] case_mem [0:MAX_CASES*NUM_FIELDS-1];      // Raw case words
    ex_rsp_t     exp_q [$];                                // Accepted, not yet returned
    int          num_cases;
    int          sent_count;                               // Requests accepted
    int          recv_count;                               // Results taken
    int          cycle_count = 0;
    int          cycle_limit;
    logic [31:0] lfsr_state;
    logic        was_held;                                 // Result stalled at last edge
    ex_rsp_t     held_rsp;                                 // Its value then
    logic        bit_a;
    logic        bit_b;

    ex_stage DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .req       (req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rsp       (rsp)
    );

    always #20 clk = ~clk;                                 // 40 ns period

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;                             // Feedback into tap positions
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = next_lfsr(lfsr_state);                // One step per bit
    endtask

    task automatic abort_run(input string why);
        $display("FAIL: see errors above");
        $fatal(1, "%s", why);
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run(what);
    endtask

    task automatic check_field(input string what, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic compare_result(input ex_rsp_t got, input ex_rsp_t exp, input string tag);
        check_field({tag, " ex_out"}, got.ex_out, exp.ex_out);
        check_field({tag, " br_taken"}, 32'(got.br_taken), 32'(exp.br_taken));
        check_field({tag, " br_addr"}, got.br_addr, exp.br_addr);
        check_field({tag, " rd_addr"}, 32'(got.rd_addr), 32'(exp.rd_addr));
        check_field({tag, " gpr_we"}, 32'(got.gpr_we), 32'(exp.gpr_we));
        check_field({tag, " hart_id"}, 32'(got.hart_id), 32'(exp.hart_id));
    endtask

    // Column order matches the data file
    function automatic ex_req_t build_request(input int idx);
        ex_req_t r;
        int      b;
        b             = idx * NUM_FIELDS;
        r.alu_op      = case_mem[b][3:0];
        r.alu_in_0    = case_mem[b + 1];
        r.alu_in_1    = case_mem[b + 2];
        r.cmp_op      = case_mem[b + 3][2:0];
        r.cmp_in_0    = case_mem[b + 4];
        r.cmp_in_1    = case_mem[b + 5];
        r.jump_taken  = case_mem[b + 6][0];
        r.is_jalr     = case_mem[b + 7][0];
        r.out_sel     = case_mem[b + 8][1:0];
        r.pc          = case_mem[b + 9];
        r.gpr_wr_data = case_mem[b + 10];
        r.rd_addr     = case_mem[b + 11][4:0];
        r.gpr_we      = case_mem[b + 12][0];
        r.hart_id     = case_mem[b + 13][1:0];
        return r;
    endfunction

    function automatic ex_rsp_t build_expected(input int idx);
        ex_rsp_t e;
        int      b;
        b          = idx * NUM_FIELDS;
        e.ex_out   = case_mem[b + 14];
        e.br_taken = case_mem[b + 15][0];
        e.br_addr  = case_mem[b + 16];
        e.rd_addr  = case_mem[b + 11][4:0];                // Same as request
        e.gpr_we   = case_mem[b + 12][0];
        e.hart_id  = case_mem[b + 13][1:0];
        return e;
    endfunction

    task automatic load_cases();
        $readmemh(CASE_FILE, case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases * NUM_FIELDS] != END_MARK) begin
            num_cases++;
        end
        if (num_cases == 0 || num_cases == MAX_CASES) begin
            report_error("case file is empty or has no end marker");
        end
    endtask

    // Values seen here are the ones the DUT sampled at this edge
    task automatic observe_edge();
        if (was_held) begin
            check_field("out_valid while held", 32'(out_valid), 32'd1);
            compare_result(rsp, held_rsp, $sformatf("held result %0d", recv_count));
        end
        assert (!(out_valid && !out_ready && in_ready)) else
            report_error("in_ready was high while the output was stalled");
        if (out_valid && out_ready) begin
            assert (exp_q.size() != 0) else
                report_error("a result arrived with no request outstanding");
            compare_result(rsp, exp_q.pop_front(), $sformatf("case %0d", recv_count));
            recv_count++;
        end
        if (in_valid && in_ready) begin
            exp_q.push_back(build_expected(sent_count));
            sent_count++;
        end
        was_held = out_valid && !out_ready;
        held_rsp = rsp;
    endtask

    task automatic drive_inputs();
        if (!(in_valid && !in_ready)) begin                // Stalled request holds
            take_bit(bit_a);
            take_bit(bit_b);
            if (sent_count < num_cases && (bit_a || bit_b)) begin
                in_valid <= 1'b1;
                req      <= build_request(sent_count);
            end else begin
                in_valid <= 1'b0;                          // Gap
            end
        end
        take_bit(bit_a);
        out_ready <= bit_a;                                // Random back-pressure
    endtask

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_error("the run timed out before all results arrived");
        end
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        req        = '0;
        sent_count = 0;
        recv_count = 0;
        was_held   = 1'b0;
        held_rsp   = '0;
        lfsr_state = LFSR_SEED;
        load_cases();
        cycle_limit = 20 * num_cases + 100;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Idle state right after reset
        check_field("out_valid after reset", 32'(out_valid), 32'd0);
        check_field("in_ready after reset", 32'(in_ready), 32'd1);
        compare_result(rsp, '0, "reset");

        while (recv_count < num_cases) begin
            observe_edge();
            drive_inputs();
            @(posedge clk);
        end

        // Nothing more may come out
        repeat (DRAIN_CYCLES) begin
            observe_edge();
            in_valid  <= 1'b0;
            out_ready <= 1'b1;
            @(posedge clk);
        end

        if (recv_count == num_cases && sent_count == num_cases && exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_error($sformatf("%0d results for %0d cases", recv_count, num_cases));
        end
    end

endmodule

`default_nettype wire

// ==== bench/ex_cases.mem ====
// Columns alu_op alu_in_0 alu_in_1 cmp_op cmp_in_0 cmp_in_1 jump jalr out_sel pc gpr rd we hart
// then expected ex_out br_taken br_addr, all hex, and a lone ffffffff ends the list
0 00000005 00000007 0 00000000 00000000 0 0 0 00000100 00000000 01 1 0 0000000c 0 00000000
0 ffffffff 00000001 0 00000000 00000000 0 0 0 00000100 00000000 02 0 1 00000000 0 00000000
1 00000005 00000007 0 00000000 00000000 0 0 0 00000100 00000000 03 1 2 fffffffe 0 00000000
2 f0f0f0f0 ff00ff00 0 00000000 00000000 0 0 0 00000100 00000000 04 1 3 f000f000 0 00000000
3 f0f0f0f0 0f0f0f0f 0 00000000 00000000 0 0 0 00000100 00000000 05 0 0 ffffffff 0 00000000
4 aaaaaaaa 5555ffff 0 00000000 00000000 0 0 0 00000100 00000000 06 1 1 ffff5555 0 00000000
5 00000001 0000001f 0 00000000 00000000 0 0 0 00000100 00000000 07 1 2 80000000 0 00000000
5 12345678 00000024 0 00000000 00000000 0 0 0 00000100 00000000 08 0 3 23456780 0 00000000
6 80000000 0000001f 0 00000000 00000000 0 0 0 00000100 00000000 09 1 0 00000001 0 00000000
7 80000000 0000001f 0 00000000 00000000 0 0 0 00000100 00000000 0a 1 1 ffffffff 0 00000000
7 f0000000 00000024 0 00000000 00000000 0 0 0 00000100 00000000 0b 0 2 ff000000 0 00000000
7 70000000 00000004 0 00000000 00000000 0 0 0 00000100 00000000 0c 1 3 07000000 0 00000000
8 ffffffff 00000001 0 00000000 00000000 0 0 0 00000100 00000000 0d 1 0 00000001 0 00000000
8 00000001 ffffffff 0 00000000 00000000 0 0 0 00000100 00000000 0e 1 1 00000000 0 00000000
9 ffffffff 00000001 0 00000000 00000000 0 0 0 00000100 00000000 0f 0 2 00000000 0 00000000
9 00000001 ffffffff 0 00000000 00000000 0 0 0 00000100 00000000 10 1 3 00000001 0 00000000
a 12345678 abcde000 0 00000000 00000000 0 0 0 00000100 00000000 11 1 0 abcde000 0 00000000
0 00001000 00000040 1 00000010 00000010 0 0 0 00001000 00000000 00 0 1 00001040 1 00001040
0 00001000 00000040 1 00000010 00000011 0 0 0 00001000 00000000 00 0 2 00001040 0 00000000
0 00002000 fffffff0 2 00000010 00000011 0 0 0 00002000 00000000 00 0 3 00001ff0 1 00001ff0
0 00002000 00000008 2 0000abcd 0000abcd 0 0 0 00002000 00000000 00 0 0 00002008 0 00000000
0 00003000 00000100 3 ffffffff 00000001 0 0 0 00003000 00000000 00 0 1 00003100 1 00003100
0 00003000 00000104 3 00000001 ffffffff 0 0 0 00003000 00000000 00 0 2 00003104 0 00000000
0 00004000 00000020 4 00000001 ffffffff 0 0 0 00004000 00000000 00 0 3 00004020 1 00004020
0 00004000 00000024 4 80000000 80000000 0 0 0 00004000 00000000 00 0 0 00004024 1 00004024
0 00004000 00000028 4 80000000 00000000 0 0 0 00004000 00000000 00 0 1 00004028 0 00000000
0 00005000 00000004 5 00000001 ffffffff 0 0 0 00005000 00000000 00 0 2 00005004 1 00005004
0 00005000 00000008 5 ffffffff 00000001 0 0 0 00005000 00000000 00 0 3 00005008 0 00000000
0 00006000 0000000c 6 ffffffff 00000001 0 0 0 00006000 00000000 00 0 0 0000600c 1 0000600c
0 00006000 00000010 6 00000007 00000007 0 0 0 00006000 00000000 00 0 1 00006010 1 00006010
0 00006000 00000014 6 00000001 00000002 0 0 0 00006000 00000000 00 0 2 00006014 0 00000000
0 00007000 00000100 0 00000000 00000000 1 0 1 00007000 00000000 01 1 0 00007004 1 00007100
0 00008001 00000010 0 00000000 00000000 1 1 1 00009000 00000000 01 1 1 00009004 1 00008010
0 0000a000 00000003 0 00000000 00000000 1 1 1 fffffffc 00000000 05 1 2 00000000 1 0000a002
0 0000b000 00000008 1 00000001 00000002 1 0 1 0000b000 00000000 00 0 3 0000b004 1 0000b008
1 00000005 00000003 0 00000000 00000000 0 0 2 00000200 deadbeef 1f 1 3 deadbeef 0 00000000
2 ffffffff 00000000 0 00000000 00000000 0 0 2 00000204 12345678 0a 0 2 12345678 0 00000000
0 00000001 00000002 0 00000000 00000000 0 0 1 00000100 00000000 12 1 1 00000104 0 00000000
ffffffff

// ==== filelist.f ====
logic/ex_pkg.sv
logic/alu_unit.sv
logic/branch_cmp.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
bench/tb_ex_stage.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench
# Exit status of the simulation is the pass or fail result

TOP       ?= tb_ex_stage
FILELIST  ?= filelist.f
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timescale 1ns/1ps -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables, override on the command line:"
	@echo "  TOP=$(TOP)"
	@echo "  FILELIST=$(FILELIST)"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  FLAGS=$(FLAGS)"
	@echo "  OBJ_DIR=$(OBJ_DIR)"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
